//--- logic/cam_regs_pkg.sv
/*
 * Shared constants and types for the camera capture peripheral.
 * Single clock domain, so the FIFO depth is kept small and a power of two.
 */

package cam_regs_pkg;

    // ------------------------------------------------------------------
    // Bus and port widths
    // ------------------------------------------------------------------
    localparam int unsigned ADDR_W = 9;     // Up to 512 word addresses
    localparam int unsigned DATA_W = 32;
    localparam int unsigned GPIO_W = 8;

    // ------------------------------------------------------------------
    // Sample FIFO sizing
    // ------------------------------------------------------------------
    localparam int unsigned FIFO_DEPTH = 16;
    localparam int unsigned FIFO_AW    = 4;     // log2 of FIFO_DEPTH
    localparam int unsigned LEVEL_W    = 5;     // Holds 0 .. FIFO_DEPTH

    // ------------------------------------------------------------------
    // Register address map
    // ------------------------------------------------------------------
    localparam logic [ADDR_W-1:0] ADR_DEVICE_ID = 9'h000;
    localparam logic [ADDR_W-1:0] ADR_REV_NUM   = 9'h001;
    localparam logic [ADDR_W-1:0] ADR_GPIO_IN   = 9'h002;
    localparam logic [ADDR_W-1:0] ADR_GPIO_OUT  = 9'h003;
    localparam logic [ADDR_W-1:0] ADR_GPIO_OE   = 9'h004;

    // FIFO window
    localparam logic [ADDR_W-1:0] ADR_FIFO_ACC  = 9'h040;   // Read pops one word
    localparam logic [ADDR_W-1:0] ADR_FIFO_FLAG = 9'h041;

    // ------------------------------------------------------------------
    // Fixed values
    // ------------------------------------------------------------------
    localparam logic [DATA_W-1:0] DEVICE_ID_VALUE = 32'hF1F0_7E57;
    localparam logic [15:0]       REV_NUM_VALUE   = 16'h0100;
    localparam logic [DATA_W-1:0] DEF_REG_VALUE   = 32'hFABD_EFAC;  // Unmapped reads
    localparam logic [GPIO_W-1:0] GPIO_RST_VALUE  = 8'h00;

    // Flag word layout, level sits in the low LEVEL_W bits
    localparam int unsigned FLAG_EMPTY_BIT = 8;
    localparam int unsigned FLAG_FULL_BIT  = 9;

    // ------------------------------------------------------------------
    // Packer beat counter
    // ------------------------------------------------------------------
    // Number of qualified beats already taken for the current word
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_B1   = 2'd1,
        ST_B2   = 2'd2,
        ST_B3   = 2'd3
    } pack_state_e;

endpackage

//--- logic/cam_regs_top.sv
/*
 * Camera capture peripheral top. Everything runs on PCLKI, so the host bus
 * must be synchronous to the camera pixel clock.
 */

`timescale 1ns/1ps

module cam_regs_top
    import cam_regs_pkg::*;
(
    input  logic              PCLKI,
    input  logic              WBs_RST_i,

    // Host bus
    input  logic [ADDR_W-1:0] wbs_adr_i,
    input  logic              wbs_cyc_i,
    input  logic [3:0]        wbs_byte_stb_i,
    input  logic              wbs_we_i,
    input  logic              wbs_stb_i,
    input  logic [DATA_W-1:0] wbs_dat_i,
    output logic [DATA_W-1:0] wbs_dat_o,
    output logic              wbs_ack_o,

    // Camera sync
    input  logic              vsync_i,
    input  logic              href_i,

    // Misc
    input  logic [GPIO_W-1:0] gpio_in_i,
    output logic [DATA_W-1:0] device_id_o,
    output logic [GPIO_W-1:0] gpio_out_o,
    output logic [GPIO_W-1:0] gpio_oe_o
);

    logic [DATA_W-1:0]  cam_word;
    logic               cam_push;
    logic               fifo_pop;
    logic [DATA_W-1:0]  fifo_head;
    logic [LEVEL_W-1:0] fifo_level;
    logic               fifo_empty;
    logic               fifo_full;

    // ------------------------------------------------------------------
    // Camera side into the FIFO
    // ------------------------------------------------------------------
    cam_word_packer u_packer (
        .PCLKI      (PCLKI),
        .WBs_RST_i  (WBs_RST_i),
        .vsync_i    (vsync_i),
        .href_i     (href_i),
        .cam_word_o (cam_word),
        .cam_push_o (cam_push)
    );

    sample_fifo u_fifo (
        .PCLKI     (PCLKI),
        .WBs_RST_i (WBs_RST_i),
        .push_i    (cam_push),
        .wdata_i   (cam_word),
        .pop_i     (fifo_pop),
        .head_o    (fifo_head),
        .level_o   (fifo_level),
        .empty_o   (fifo_empty),
        .full_o    (fifo_full)
    );

    // Host side
    wb_reg_bank u_regs (
        .PCLKI          (PCLKI),
        .WBs_RST_i      (WBs_RST_i),
        .wbs_adr_i      (wbs_adr_i),
        .wbs_cyc_i      (wbs_cyc_i),
        .wbs_byte_stb_i (wbs_byte_stb_i),
        .wbs_we_i       (wbs_we_i),
        .wbs_stb_i      (wbs_stb_i),
        .wbs_dat_i      (wbs_dat_i),
        .wbs_dat_o      (wbs_dat_o),
        .wbs_ack_o      (wbs_ack_o),
        .gpio_in_i      (gpio_in_i),
        .gpio_out_o     (gpio_out_o),
        .gpio_oe_o      (gpio_oe_o),
        .device_id_o    (device_id_o),
        .fifo_head_i    (fifo_head),
        .fifo_level_i   (fifo_level),
        .fifo_empty_i   (fifo_empty),
        .fifo_full_i    (fifo_full),
        .fifo_pop_o     (fifo_pop)
    );

endmodule

//--- logic/cam_word_packer.sv
/*
 * Counts qualified camera beats (vsync_i and href_i high) and emits one
 * word per four beats. Pixel data is not carried, the word is a sequence number.
 */

`timescale 1ns/1ps

module cam_word_packer
    import cam_regs_pkg::*;
(
    input  logic              PCLKI,
    input  logic              WBs_RST_i,
    input  logic              vsync_i,
    input  logic              href_i,
    output logic [DATA_W-1:0] cam_word_o,
    output logic              cam_push_o
);

    pack_state_e       state;
    logic              beat_vld;
    logic              word_done;
    logic [DATA_W-1:0] seq_num;

    assign beat_vld  = vsync_i & href_i;            // Frame and line both active
    assign word_done = beat_vld & (state == ST_B3);

    // ------------------------------------------------------------------
    // Beat counter and sequence number
    // ------------------------------------------------------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i) begin
        if (WBs_RST_i) begin
            state      <= ST_IDLE;
            seq_num    <= '0;
            cam_push_o <= 1'b0;
        end else begin
            cam_push_o <= word_done;                // One cycle pulse
            if (beat_vld) begin
                case (state)
                    ST_IDLE: state <= ST_B1;
                    ST_B1:   state <= ST_B2;
                    ST_B2:   state <= ST_B3;
                    default: state <= ST_IDLE;
                endcase
            end
            // Advances even if the FIFO later drops the word
            if (word_done)
                seq_num <= seq_num + 1'b1;
        end
    end

    // Word register, only meaningful while cam_push_o is high
    always_ff @(posedge PCLKI) begin
        if (word_done)
            cam_word_o <= seq_num;
    end

endmodule

//--- logic/sample_fifo.sv
/*
 * Synchronous register-array FIFO. A push when full and a pop when empty
 * are dropped silently. head_o shows the oldest entry without a read latency.
 */

`timescale 1ns/1ps

module sample_fifo
    import cam_regs_pkg::*;
(
    input  logic               PCLKI,
    input  logic               WBs_RST_i,
    input  logic               push_i,
    input  logic [DATA_W-1:0]  wdata_i,
    input  logic               pop_i,
    output logic [DATA_W-1:0]  head_o,
    output logic [LEVEL_W-1:0] level_o,
    output logic               empty_o,
    output logic               full_o
);

    logic [DATA_W-1:0]  mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [LEVEL_W-1:0] count;
    logic               do_push;
    logic               do_pop;

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // ------------------------------------------------------------------
    // Pointers and level
    // ------------------------------------------------------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i) begin
        if (WBs_RST_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at FIFO_DEPTH
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;

            // Both at once leaves the level unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge PCLKI) begin
        if (do_push)
            mem[wr_ptr] <= wdata_i;
    end

    assign head_o  = mem[rd_ptr];
    assign level_o = count;
    assign empty_o = (count == '0);
    assign full_o  = (count == LEVEL_W'(FIFO_DEPTH));

endmodule

//--- logic/wb_reg_bank.sv
/*
 * Wishbone-style register port. Every request is answered one clock later
 * with a single-cycle ack, no wait states. Only byte lane 0 is writable.
 */

`timescale 1ns/1ps

module wb_reg_bank
    import cam_regs_pkg::*;
(
    input  logic               PCLKI,
    input  logic               WBs_RST_i,

    // Host bus
    input  logic [ADDR_W-1:0]  wbs_adr_i,
    input  logic               wbs_cyc_i,
    input  logic [3:0]         wbs_byte_stb_i,
    input  logic               wbs_we_i,
    input  logic               wbs_stb_i,
    input  logic [DATA_W-1:0]  wbs_dat_i,
    output logic [DATA_W-1:0]  wbs_dat_o,
    output logic               wbs_ack_o,

    // GPIO and ID
    input  logic [GPIO_W-1:0]  gpio_in_i,
    output logic [GPIO_W-1:0]  gpio_out_o,
    output logic [GPIO_W-1:0]  gpio_oe_o,
    output logic [DATA_W-1:0]  device_id_o,

    // Sample FIFO
    input  logic [DATA_W-1:0]  fifo_head_i,
    input  logic [LEVEL_W-1:0] fifo_level_i,
    input  logic               fifo_empty_i,
    input  logic               fifo_full_i,
    output logic               fifo_pop_o
);

    logic              bus_req;
    logic              ack_nxt;
    logic              gpio_out_wr;
    logic              gpio_oe_wr;
    logic [DATA_W-1:0] flag_word;

    // ------------------------------------------------------------------
    // Request decode
    // ------------------------------------------------------------------
    assign bus_req = wbs_cyc_i & wbs_stb_i;
    assign ack_nxt = bus_req & ~wbs_ack_o;      // Held request acks every other cycle

    // Writes land on the edge that raises ack
    assign gpio_out_wr = ack_nxt & wbs_we_i & wbs_byte_stb_i[0]
                         & (wbs_adr_i == ADR_GPIO_OUT);
    assign gpio_oe_wr  = ack_nxt & wbs_we_i & wbs_byte_stb_i[0]
                         & (wbs_adr_i == ADR_GPIO_OE);

    // High during the ack cycle, FIFO advances on the edge that ends it
    assign fifo_pop_o = wbs_ack_o & bus_req & ~wbs_we_i & ~fifo_empty_i
                        & (wbs_adr_i == ADR_FIFO_ACC);

    // ------------------------------------------------------------------
    // Ack and GPIO registers
    // ------------------------------------------------------------------
    always_ff @(posedge PCLKI or posedge WBs_RST_i) begin
        if (WBs_RST_i) begin
            wbs_ack_o  <= 1'b0;
            gpio_out_o <= GPIO_RST_VALUE;
            gpio_oe_o  <= GPIO_RST_VALUE;
        end else begin
            wbs_ack_o <= ack_nxt;
            if (gpio_out_wr)
                gpio_out_o <= wbs_dat_i[GPIO_W-1:0];
            if (gpio_oe_wr)
                gpio_oe_o <= wbs_dat_i[GPIO_W-1:0];
        end
    end

    // ------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------
    always_comb begin
        flag_word                 = '0;
        flag_word[LEVEL_W-1:0]    = fifo_level_i;
        flag_word[FLAG_EMPTY_BIT] = fifo_empty_i;
        flag_word[FLAG_FULL_BIT]  = fifo_full_i;
    end

    assign device_id_o = DEVICE_ID_VALUE;

    // Purely from the address, valid while ack is high
    always_comb begin
        case (wbs_adr_i)
            ADR_DEVICE_ID: wbs_dat_o = DEVICE_ID_VALUE;
            ADR_REV_NUM:   wbs_dat_o = {16'h0000, REV_NUM_VALUE};
            ADR_GPIO_IN:   wbs_dat_o = {{(DATA_W-GPIO_W){1'b0}}, gpio_in_i};
            ADR_GPIO_OUT:  wbs_dat_o = {{(DATA_W-GPIO_W){1'b0}}, gpio_out_o};
            ADR_GPIO_OE:   wbs_dat_o = {{(DATA_W-GPIO_W){1'b0}}, gpio_oe_o};
            ADR_FIFO_ACC:  wbs_dat_o = fifo_head_i;     // Head before the pop
            ADR_FIFO_FLAG: wbs_dat_o = flag_word;
            default:       wbs_dat_o = DEF_REG_VALUE;
        endcase
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the camera register testbench with Verilator
set -e -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_cam_regs -f tb.f -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0

//--- tb.f
logic/cam_regs_pkg.sv
logic/cam_word_packer.sv
logic/sample_fifo.sv
logic/wb_reg_bank.sv
logic/cam_regs_top.sv
test/cam_regs_asserts.sv
test/tb_cam_regs.sv

//--- test/cam_regs_asserts.sv
/*
 * Bus and FIFO protocol checks, bound into cam_regs_top.
 */

`timescale 1ns/1ps

module cam_regs_asserts
    import cam_regs_pkg::*;
(
    input  logic               PCLKI,
    input  logic               WBs_RST_i,
    input  logic               cyc_i,
    input  logic               stb_i,
    input  logic               ack_i,
    input  logic [LEVEL_W-1:0] fifo_level_i,
    input  logic               fifo_empty_i,
    input  logic               fifo_pop_i
);

    // ------------------------------------------------------------------
    // Bus acknowledge
    // ------------------------------------------------------------------
    ack_single: assert property (@(posedge PCLKI) disable iff (WBs_RST_i)
        ack_i |=> !ack_i)
        else $error("ack held high for two cycles");

    ack_after_req: assert property (@(posedge PCLKI) disable iff (WBs_RST_i)
        ack_i |-> $past(cyc_i && stb_i))
        else $error("ack without a request in the previous cycle");

    // FIFO
    level_bound: assert property (@(posedge PCLKI) disable iff (WBs_RST_i)
        fifo_level_i <= LEVEL_W'(FIFO_DEPTH))
        else $error("FIFO level above its depth");

    pop_not_empty: assert property (@(posedge PCLKI) disable iff (WBs_RST_i)
        fifo_pop_i |-> !fifo_empty_i)
        else $error("FIFO pop while empty");

endmodule

bind cam_regs_top cam_regs_asserts u_asserts (
    .PCLKI        (PCLKI),
    .WBs_RST_i    (WBs_RST_i),
    .cyc_i        (wbs_cyc_i),
    .stb_i        (wbs_stb_i),
    .ack_i        (wbs_ack_o),
    .fifo_level_i (fifo_level),
    .fifo_empty_i (fifo_empty),
    .fifo_pop_i   (fifo_pop)
);

//--- test/tb_cam_regs.sv
/*
 * Table-driven testbench for cam_regs_top. Inputs change 1 ns after the rising
 * edge and outputs are sampled on the falling edge. Expects a fresh reset.
 */

`timescale 1ns/1ps

module tb_cam_regs
    import cam_regs_pkg::*;
();

    localparam int                ACK_TIMEOUT = 16;     // Cycles allowed per bus access
    localparam int                CAP_WORDS   = 3;      // Words in the plain capture run
    localparam logic [31:0]       SEED        = 32'h77c8;
    localparam logic [DATA_W-1:0] FULL_MASK   = 32'hFFFF_FFFF;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_CAM} op_e;

    typedef struct packed {
        op_e               kind;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] data;    // Write data, or gpio_in_i value on reads
        logic [3:0]        bstb;
        int                beats;   // Qualified camera beats
        logic [DATA_W-1:0] exp;
        logic [DATA_W-1:0] mask;    // Zero checks only the ack
    } step_t;

    logic              PCLKI;
    logic              WBs_RST_i;
    logic [ADDR_W-1:0] wbs_adr_i;
    logic              wbs_cyc_i;
    logic [3:0]        wbs_byte_stb_i;
    logic              wbs_we_i;
    logic              wbs_stb_i;
    logic [DATA_W-1:0] wbs_dat_i;
    logic [DATA_W-1:0] wbs_dat_o;
    logic              wbs_ack_o;
    logic              vsync_i;
    logic              href_i;
    logic [GPIO_W-1:0] gpio_in_i;
    logic [DATA_W-1:0] device_id_o;
    logic [GPIO_W-1:0] gpio_out_o;
    logic [GPIO_W-1:0] gpio_oe_o;

    step_t             steps[$];
    int                err_cnt = 0;
    int                to_cnt  = 0;

    cam_regs_top dut (.*);

    initial begin
        PCLKI = 1'b0;
        forever #4 PCLKI = ~PCLKI;     // 8 ns period
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic add_step(input op_e kind, input logic [ADDR_W-1:0] adr,
                            input logic [DATA_W-1:0] data, input logic [3:0] bstb,
                            input int beats, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] mask);
        steps.push_back('{kind, adr, data, bstb, beats, exp, mask});
    endtask

    // Level in the low bits, empty and full at their flag positions
    function automatic logic [DATA_W-1:0] flag_exp(input int level, input logic empty,
                                                   input logic full);
        logic [DATA_W-1:0] w;
        w = '0;
        w[LEVEL_W-1:0]    = level[LEVEL_W-1:0];
        w[FLAG_EMPTY_BIT] = empty;
        w[FLAG_FULL_BIT]  = full;
        return w;
    endfunction

    task automatic bus_cycle(input logic we, input logic [ADDR_W-1:0] adr,
                             input logic [DATA_W-1:0] dat, input logic [3:0] bstb,
                             output logic [DATA_W-1:0] rdata);
        int   wait_cnt;
        logic acked;
        wait_cnt = 0;
        acked    = 1'b0;
        rdata    = '0;
        @(posedge PCLKI);
        #1;
        wbs_adr_i      = adr;
        wbs_dat_i      = dat;
        wbs_byte_stb_i = bstb;
        wbs_we_i       = we;
        wbs_cyc_i      = 1'b1;
        wbs_stb_i      = 1'b1;
        while (!acked && wait_cnt < ACK_TIMEOUT) begin
            @(negedge PCLKI);
            if (wbs_ack_o) begin
                acked = 1'b1;
                rdata = wbs_dat_o;
            end else begin
                wait_cnt++;
            end
        end
        if (!acked) begin
            to_cnt++;
            $display("timeout: no ack within %0d cycles at address 0x%0h", ACK_TIMEOUT, adr);
        end
        @(posedge PCLKI);
        #1;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
    endtask

    // Each qualified beat follows one beat with only vsync or only href high
    task automatic drive_beats(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(posedge PCLKI);
            #1;
            vsync_i = i[0];
            href_i  = ~i[0];
            @(posedge PCLKI);
            #1;
            vsync_i = 1'b1;
            href_i  = 1'b1;
        end
        @(posedge PCLKI);
        #1;
        vsync_i = 1'b0;
        href_i  = 1'b0;
        repeat (2) @(posedge PCLKI);    // Packer then FIFO register the last word
    endtask

    // ------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------
    task automatic build_table();
        int               seq;
        int               i;
        logic [DATA_W-1:0] r;
        seq = 0;
        add_step(OP_RD, ADR_DEVICE_ID, '0, '0, 0, DEVICE_ID_VALUE, FULL_MASK);
        add_step(OP_RD, ADR_REV_NUM, '0, '0, 0, {16'h0000, REV_NUM_VALUE}, FULL_MASK);
        add_step(OP_RD, 9'h155, '0, '0, 0, DEF_REG_VALUE, FULL_MASK);  // Unmapped
        add_step(OP_RD, ADR_GPIO_OUT, '0, '0, 0, '0, FULL_MASK);
        add_step(OP_RD, ADR_FIFO_FLAG, '0, '0, 0, flag_exp(0, 1'b1, 1'b0), FULL_MASK);
        // GPIO registers, lane 0 only
        add_step(OP_WR, ADR_GPIO_OUT, 32'h0000_00A5, 4'b0001, 0, '0, '0);
        add_step(OP_RD, ADR_GPIO_OUT, '0, '0, 0, 32'h0000_00A5, FULL_MASK);
        add_step(OP_WR, ADR_GPIO_OE, 32'hFFFF_FF3C, 4'b1111, 0, '0, '0);
        add_step(OP_RD, ADR_GPIO_OE, '0, '0, 0, 32'h0000_003C, FULL_MASK);
        add_step(OP_WR, ADR_GPIO_OUT, 32'h0000_005A, 4'b1110, 0, '0, '0);
        add_step(OP_RD, ADR_GPIO_OUT, '0, '0, 0, 32'h0000_00A5, FULL_MASK);
        for (i = 0; i < 4; i++) begin
            r = $urandom & 32'h0000_00FF;
            add_step(OP_RD, ADR_GPIO_IN, r, '0, 0, r, FULL_MASK);
        end
        // Plain capture
        add_step(OP_CAM, '0, '0, '0, 4 * CAP_WORDS, '0, '0);
        add_step(OP_RD, ADR_FIFO_FLAG, '0, '0, 0, flag_exp(CAP_WORDS, 1'b0, 1'b0), FULL_MASK);
        for (i = 0; i < CAP_WORDS; i++) begin
            add_step(OP_RD, ADR_FIFO_ACC, '0, '0, 0, seq, FULL_MASK);
            seq++;
        end
        add_step(OP_RD, ADR_FIFO_FLAG, '0, '0, 0, flag_exp(0, 1'b1, 1'b0), FULL_MASK);
        // Overflow, the last four words are dropped
        add_step(OP_CAM, '0, '0, '0, 4 * (FIFO_DEPTH + 4), '0, '0);
        add_step(OP_RD, ADR_FIFO_FLAG, '0, '0, 0, flag_exp(FIFO_DEPTH, 1'b0, 1'b1),
                 FULL_MASK);
        for (i = 0; i < FIFO_DEPTH; i++) begin
            add_step(OP_RD, ADR_FIFO_ACC, '0, '0, 0, seq, FULL_MASK);
            seq++;
        end
        seq = seq + 4;
        add_step(OP_CAM, '0, '0, '0, 16, '0, '0);
        for (i = 0; i < 4; i++) begin
            add_step(OP_RD, ADR_FIFO_ACC, '0, '0, 0, seq, FULL_MASK);
            seq++;
        end
        // Read of an empty FIFO, data is stale
        add_step(OP_RD, ADR_FIFO_ACC, '0, '0, 0, '0, '0);
        add_step(OP_RD, ADR_FIFO_FLAG, '0, '0, 0, flag_exp(0, 1'b1, 1'b0), FULL_MASK);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int                k;
        logic [DATA_W-1:0] rdata;
        logic [GPIO_W-1:0] exp_out;
        logic [GPIO_W-1:0] exp_oe;
        WBs_RST_i      = 1'b1;
        wbs_adr_i      = '0;
        wbs_cyc_i      = 1'b0;
        wbs_byte_stb_i = '0;
        wbs_we_i       = 1'b0;
        wbs_stb_i      = 1'b0;
        wbs_dat_i      = '0;
        vsync_i        = 1'b0;
        href_i         = 1'b0;
        gpio_in_i      = '0;
        exp_out        = '0;
        exp_oe         = '0;
        void'($urandom(SEED));
        build_table();
        repeat (4) @(posedge PCLKI);
        #1;
        WBs_RST_i = 1'b0;

        assert (gpio_out_o == 8'h00 && gpio_oe_o == 8'h00 && !wbs_ack_o) else begin
            err_cnt++;
            $display("error: reset gpio_out_o 0x%02h gpio_oe_o 0x%02h wbs_ack_o 0x%0h",
                     gpio_out_o, gpio_oe_o, wbs_ack_o);
        end
        assert (device_id_o == DEVICE_ID_VALUE) else begin
            err_cnt++;
            $display("error: device_id_o got 0x%08h expected 0x%08h",
                     device_id_o, DEVICE_ID_VALUE);
        end

        for (k = 0; k < steps.size(); k++) begin
            case (steps[k].kind)
                OP_WR: begin
                    bus_cycle(1'b1, steps[k].adr, steps[k].data, steps[k].bstb, rdata);
                    if (steps[k].bstb[0] && steps[k].adr == ADR_GPIO_OUT)
                        exp_out = steps[k].data[GPIO_W-1:0];
                    if (steps[k].bstb[0] && steps[k].adr == ADR_GPIO_OE)
                        exp_oe = steps[k].data[GPIO_W-1:0];
                    assert (gpio_out_o == exp_out && gpio_oe_o == exp_oe) else begin
                        err_cnt++;
                        $display("error: gpio_out_o/gpio_oe_o got %02h/%02h expected %02h/%02h",
                                 gpio_out_o, gpio_oe_o, exp_out, exp_oe);
                    end
                end
                OP_RD: begin
                    gpio_in_i = steps[k].data[GPIO_W-1:0];
                    bus_cycle(1'b0, steps[k].adr, '0, 4'b1111, rdata);
                    if (steps[k].mask != '0) begin
                        assert ((rdata & steps[k].mask) == (steps[k].exp & steps[k].mask))
                        else begin
                            err_cnt++;
                            $display("error: wbs_dat_o at 0x%03h got 0x%08h expected 0x%08h",
                                     steps[k].adr, rdata, steps[k].exp);
                        end
                    end
                end
                default: drive_beats(steps[k].beats);
            endcase
        end

        $display("steps %0d, value errors %0d, timeouts %0d", steps.size(), err_cnt, to_cnt);
        if (err_cnt == 0 && to_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule
